// ==== common/lz_pkg.sv ====
// shared sizes and types of the lz77 tokenizer
// sequencing word, match status, consume feedback
// token payload union and token struct
// search-end rule used by sequencing and result
`default_nettype none

package lz_pkg;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int WIN_SIZE = 16;
  localparam int MAX_LEN  = 8;
  localparam int MIN_LEN  = 3;
  localparam int BYTE_W   = 8;
  localparam int LEN_W    = 4;
  localparam int DST_W    = 5;
  localparam int CNT_W    = 16;

  typedef logic [BYTE_W-1:0] byte_t;

  // ----------------------------------------
  // block to block words
  // ----------------------------------------
  // sequencing word from lz_ctrl
  typedef struct packed {
    logic             fetch;
    logic             search;
    logic             sch_first;
    logic [LEN_W-1:0] sch_step;
    logic [LEN_W-1:0] look_cnt;
    logic [DST_W-1:0] win_cnt;
  } lz_ctrl_t;

  // alive flag bit d-1 stands for distance d
  typedef struct packed {
    logic [WIN_SIZE-1:0] alive;
    logic                any_alive;
    logic [DST_W-1:0]    first_dist;
  } match_sts_t;

  // bytes covered by the token just emitted
  typedef struct packed {
    logic             valid;
    logic [LEN_W-1:0] len;
  } consume_t;

  // ----------------------------------------
  // token
  // ----------------------------------------
  typedef struct packed {
    logic  rsvd;
    byte_t data;
  } lz_lit_t;

  typedef struct packed {
    logic [LEN_W-1:0] len;
    logic [DST_W-1:0] dst;
  } lz_pair_t;

  // decoded by is_lit
  typedef union packed {
    lz_lit_t  lit;
    lz_pair_t pair;
  } tok_payload_u;

  typedef struct packed {
    logic         is_lit;
    logic         last;
    tok_payload_u payload;
  } lz_token_t;

  // search stops when nothing is left alive or the lookahead is used up
  function automatic logic sch_done(lz_ctrl_t ctrl, match_sts_t sts);
    return ctrl.search && (!sts.any_alive || (ctrl.sch_step == ctrl.look_cnt - 1'b1));
  endfunction

endpackage

`default_nettype wire

// ==== list.f ====
common/lz_pkg.sv
rtl/lz_ctrl.sv
window/lz_window.sv
match/lz_match.sv
rtl/lz_token.sv
rtl/lz_top.sv
verif/lz_props.sv
verif/tb_lz.sv

// ==== match/lz_match.sv ====
// parallel match search over all window distances
// one alive flag per distance, narrowed one lookahead byte per step
// smallest alive distance by priority pick
`timescale 1ns/1ps
`default_nettype none

module lz_match (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  lz_pkg::lz_ctrl_t                     ctrl_i,
  input  lz_pkg::byte_t [lz_pkg::MAX_LEN-1:0]  look_i,
  input  lz_pkg::byte_t [lz_pkg::WIN_SIZE-1:0] win_i,
  output lz_pkg::match_sts_t                   sts_o
);
  import lz_pkg::*;

  logic [WIN_SIZE-1:0] alive_q;
  logic [WIN_SIZE-1:0] alive_d;
  logic [WIN_SIZE-1:0] cand;
  logic [DST_W-1:0]    first_dist;
  byte_t               look_byte;
  byte_t               hist_byte;

  // ----------------------------------------
  // per-distance compare
  // ----------------------------------------
  always_comb begin
    // lookahead byte k
    look_byte = '0;
    for (int i = 0; i < MAX_LEN; i++) begin
      if (int'(ctrl_i.sch_step) == i) begin
        look_byte = look_i[i];
      end
    end
    for (int d = 1; d <= WIN_SIZE; d++) begin
      // history byte d-k back sits in entry d-k-1
      hist_byte = '0;
      for (int j = 0; j < WIN_SIZE; j++) begin
        if (j + int'(ctrl_i.sch_step) == d - 1) begin
          hist_byte = win_i[j];
        end
      end
      // only distances reaching into emitted bytes start alive
      if (ctrl_i.sch_first) begin
        cand[d-1] = (d <= int'(ctrl_i.win_cnt));
      end else begin
        cand[d-1] = alive_q[d-1];
      end
      // k below d keeps the length within the distance
      alive_d[d-1] = cand[d-1] && (int'(ctrl_i.sch_step) < d) && (look_byte == hist_byte);
    end
  end

  // ----------------------------------------
  // priority pick
  // ----------------------------------------
  always_comb begin
    first_dist = '0;
    for (int d = WIN_SIZE; d >= 1; d--) begin
      if (alive_d[d-1]) begin
        first_dist = DST_W'(d);
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      alive_q <= '0;
    end else if (ctrl_i.search) begin
      alive_q <= alive_d;
    end
  end

  always_comb begin
    sts_o            = '0;
    sts_o.alive      = alive_d;
    sts_o.any_alive  = |alive_d;
    sts_o.first_dist = first_dist;
  end

endmodule

`default_nettype wire

// ==== rtl/lz_ctrl.sv ====
// sequencing FSM of the tokenizer
// idle, fetch, search and consume phases
// stream counters, source read strobe, last flag and done pulse
`timescale 1ns/1ps
`default_nettype none

module lz_ctrl (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start_i,
  input  logic [lz_pkg::CNT_W-1:0] cfg_len_i,
  output logic                     src_rd_o,
  output lz_pkg::lz_ctrl_t         ctrl_o,
  input  lz_pkg::match_sts_t       sts_i,
  input  lz_pkg::consume_t         consume_i,
  output logic                     last_o,
  output logic                     done_o
);
  import lz_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FETCH,
    ST_SEARCH,
    ST_CONSUME
  } state_t;

  state_t           state_q;
  state_t           state_d;
  logic [CNT_W-1:0] len_q;
  logic [CNT_W-1:0] fetch_cnt_q;
  logic [CNT_W-1:0] remain_q;
  logic [LEN_W-1:0] look_cnt_q;
  logic [LEN_W-1:0] step_q;
  logic [DST_W-1:0] win_cnt_q;
  logic [DST_W:0]   win_sum;
  logic             last_fetch;
  logic             more_fetch;
  logic             search_end;
  logic             stream_end;

  // ----------------------------------------
  // decode
  // ----------------------------------------
  assign src_rd_o   = (state_q == ST_FETCH);
  // lookahead full or stream fully read after this byte
  assign last_fetch = (look_cnt_q == LEN_W'(MAX_LEN - 1)) || (fetch_cnt_q == len_q - 1'b1);
  assign more_fetch = (fetch_cnt_q != len_q);
  assign search_end = sch_done(ctrl_o, sts_i);
  assign stream_end = (remain_q == CNT_W'(consume_i.len));
  assign last_o     = consume_i.valid && stream_end;
  assign win_sum    = {1'b0, win_cnt_q} + (DST_W+1)'(consume_i.len);

  always_comb begin
    ctrl_o           = '0;
    ctrl_o.fetch     = src_rd_o;
    ctrl_o.search    = (state_q == ST_SEARCH);
    ctrl_o.sch_first = (state_q == ST_SEARCH) && (step_q == '0);
    ctrl_o.sch_step  = step_q;
    ctrl_o.look_cnt  = look_cnt_q;
    ctrl_o.win_cnt   = win_cnt_q;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        // an empty stream is not started
        if (start_i && (cfg_len_i != '0)) begin
          state_d = ST_FETCH;
        end
      end
      ST_FETCH: begin
        if (last_fetch) begin
          state_d = ST_SEARCH;
        end
      end
      ST_SEARCH: begin
        if (search_end) begin
          state_d = ST_CONSUME;
        end
      end
      ST_CONSUME: begin
        if (consume_i.valid) begin
          if (stream_end) begin
            state_d = ST_IDLE;
          end else if (more_fetch) begin
            state_d = ST_FETCH;
          end else begin
            state_d = ST_SEARCH;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // ----------------------------------------
  // state and counters
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q     <= ST_IDLE;
      len_q       <= '0;
      fetch_cnt_q <= '0;
      remain_q    <= '0;
      look_cnt_q  <= '0;
      win_cnt_q   <= '0;
      step_q      <= '0;
    end else begin
      state_q <= state_d;
      case (state_q)
        ST_IDLE: begin
          if (state_d == ST_FETCH) begin
            len_q       <= cfg_len_i;
            remain_q    <= cfg_len_i;
            fetch_cnt_q <= '0;
            look_cnt_q  <= '0;
            win_cnt_q   <= '0;
          end
        end
        ST_FETCH: begin
          fetch_cnt_q <= fetch_cnt_q + 1'b1;
          look_cnt_q  <= look_cnt_q + 1'b1;
        end
        ST_SEARCH: begin
          if (search_end) begin
            step_q <= '0;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        ST_CONSUME: begin
          if (consume_i.valid) begin
            look_cnt_q <= look_cnt_q - consume_i.len;
            remain_q   <= remain_q - CNT_W'(consume_i.len);
            // history saturates at the window depth
            if (win_sum > (DST_W+1)'(WIN_SIZE)) begin
              win_cnt_q <= DST_W'(WIN_SIZE);
            end else begin
              win_cnt_q <= win_sum[DST_W-1:0];
            end
          end
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      done_o <= 1'b0;
    end else begin
      done_o <= last_o;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lz_token.sv ====
// token result stage
// tracks the best length and distance over the search steps
// literal or match decision and the registered token
`timescale 1ns/1ps
`default_nettype none

module lz_token (
  input  logic               clk,
  input  logic               rstn,
  input  lz_pkg::lz_ctrl_t   ctrl_i,
  input  lz_pkg::match_sts_t sts_i,
  input  lz_pkg::byte_t      look_i,
  input  logic               last_i,
  output lz_pkg::consume_t   consume_o,
  output logic               tok_valid_o,
  output lz_pkg::lz_token_t  tok_o
);
  import lz_pkg::*;

  logic [LEN_W-1:0] best_len_q;
  logic [DST_W-1:0] best_dst_q;
  logic [LEN_W-1:0] cur_len;
  logic [DST_W-1:0] cur_dst;
  logic [LEN_W-1:0] len_q;
  logic             keep;
  logic             sch_end;
  logic             is_lit_q;
  logic             valid_q;
  tok_payload_u     payload_d;
  tok_payload_u     payload_q;

  assign sch_end = sch_done(ctrl_i, sts_i);

  // best so far including this step
  always_comb begin
    if (sts_i.any_alive) begin
      cur_len = ctrl_i.sch_step + 1'b1;
      cur_dst = sts_i.first_dist;
    end else if (ctrl_i.sch_first) begin
      cur_len = '0;
      cur_dst = '0;
    end else begin
      cur_len = best_len_q;
      cur_dst = best_dst_q;
    end
  end

  assign keep = (cur_len >= LEN_W'(MIN_LEN));

  always_comb begin
    payload_d = '0;
    if (keep) begin
      payload_d.pair.len = cur_len;
      payload_d.pair.dst = cur_dst;
    end else begin
      payload_d.lit.data = look_i;
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      best_len_q <= '0;
      best_dst_q <= '0;
      valid_q    <= 1'b0;
      is_lit_q   <= 1'b0;
      len_q      <= '0;
    end else begin
      valid_q <= sch_end;
      if (ctrl_i.search) begin
        best_len_q <= cur_len;
        best_dst_q <= cur_dst;
      end
      if (sch_end) begin
        is_lit_q <= !keep;
        len_q    <= keep ? cur_len : LEN_W'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sch_end) begin
      payload_q <= payload_d;
    end
  end

  assign consume_o.valid = valid_q;
  assign consume_o.len   = len_q;
  assign tok_valid_o     = valid_q;
  assign tok_o.is_lit    = is_lit_q;
  assign tok_o.last      = last_i;
  assign tok_o.payload   = payload_q;

endmodule

`default_nettype wire

// ==== rtl/lz_top.sv ====
// lz77 tokenizer top level
// sequencing, window storage, match search and token result
`timescale 1ns/1ps
`default_nettype none

module lz_top (
  input  logic                     clk,
  input  logic                     rstn,
  input  logic                     start_i,
  input  logic [lz_pkg::CNT_W-1:0] cfg_len_i,
  output logic                     src_rd_o,
  input  lz_pkg::byte_t            src_data_i,
  output logic                     tok_valid_o,
  output lz_pkg::lz_token_t        tok_o,
  output logic                     done_o
);
  import lz_pkg::*;

  lz_ctrl_t             ctrl;
  match_sts_t           sts;
  consume_t             consume;
  byte_t [MAX_LEN-1:0]  look;
  byte_t [WIN_SIZE-1:0] win;
  logic                 last;

  lz_ctrl ctrl_i (
    .clk       (clk),
    .rstn      (rstn),
    .start_i   (start_i),
    .cfg_len_i (cfg_len_i),
    .src_rd_o  (src_rd_o),
    .ctrl_o    (ctrl),
    .sts_i     (sts),
    .consume_i (consume),
    .last_o    (last),
    .done_o    (done_o)
  );

  lz_window window_i (
    .clk        (clk),
    .rstn       (rstn),
    .ctrl_i     (ctrl),
    .src_data_i (src_data_i),
    .consume_i  (consume),
    .look_o     (look),
    .win_o      (win)
  );

  lz_match match_i (
    .clk    (clk),
    .rstn   (rstn),
    .ctrl_i (ctrl),
    .look_i (look),
    .win_i  (win),
    .sts_o  (sts)
  );

  // the literal is always the lookahead head
  lz_token token_i (
    .clk         (clk),
    .rstn        (rstn),
    .ctrl_i      (ctrl),
    .sts_i       (sts),
    .look_i      (look[0]),
    .last_i      (last),
    .consume_o   (consume),
    .tok_valid_o (tok_valid_o),
    .tok_o       (tok_o)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the tokenizer testbench with Verilator, run it and grep the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_lz \
  -Mdir obj_dir -o tb_lz_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_lz_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation ended with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
  echo "result: fail"
  exit 1
fi

echo "result: pass"
exit 0

// ==== verif/lz_props.sv ====
// protocol checks on the tokenizer top level
// done pulse after the last token, single-cycle token pulse
// no source read while idle, match length and distance bounds
`timescale 1ns/1ps
`default_nettype none

module lz_props (
  input logic                     clk,
  input logic                     rstn,
  input logic                     start_i,
  input logic [lz_pkg::CNT_W-1:0] cfg_len_i,
  input logic                     src_rd_i,
  input logic                     tok_valid_i,
  input lz_pkg::lz_token_t        tok_i,
  input logic                     done_i
);
  import lz_pkg::*;

  logic busy_q;
  logic last_tok;
  logic match_ok;
  // failed checks, summed up by the testbench
  int   err_cnt = 0;

  assign last_tok = tok_valid_i && tok_i.last;
  assign match_ok = (tok_i.payload.pair.len >= LEN_W'(MIN_LEN)) &&
                    (tok_i.payload.pair.len <= LEN_W'(MAX_LEN)) &&
                    ({1'b0, tok_i.payload.pair.len} <= tok_i.payload.pair.dst);

  // busy from an accepted start until the last token
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      busy_q <= 1'b0;
    end else if (!busy_q && start_i && (cfg_len_i != '0)) begin
      busy_q <= 1'b1;
    end else if (last_tok) begin
      busy_q <= 1'b0;
    end
  end

  // ----------------------------------------
  done_after_last: assert property (@(posedge clk) disable iff (!rstn)
    last_tok |=> done_i)
    else begin
      $error("done_o missing one cycle after the last token");
      err_cnt++;
    end

  done_only_after_last: assert property (@(posedge clk) disable iff (!rstn)
    done_i |-> $past(last_tok))
    else begin
      $error("done_o without a last token one cycle before");
      err_cnt++;
    end

  tok_single_cycle: assert property (@(posedge clk) disable iff (!rstn)
    tok_valid_i |=> !tok_valid_i)
    else begin
      $error("tok_valid_o high for more than one cycle");
      err_cnt++;
    end

  idle_no_read: assert property (@(posedge clk) disable iff (!rstn)
    !busy_q |-> !src_rd_i)
    else begin
      $error("src_rd_o high while idle");
      err_cnt++;
    end

  match_bounds: assert property (@(posedge clk) disable iff (!rstn)
    (tok_valid_i && !tok_i.is_lit) |-> match_ok)
    else begin
      $error("match token with length or distance out of range");
      err_cnt++;
    end

endmodule

bind lz_top lz_props props_i (
  .clk         (clk),
  .rstn        (rstn),
  .start_i     (start_i),
  .cfg_len_i   (cfg_len_i),
  .src_rd_i    (src_rd_o),
  .tok_valid_i (tok_valid_o),
  .tok_i       (tok_o),
  .done_i      (done_o)
);

`default_nettype wire

// ==== verif/tb_lz.sv ====
// testbench of the lz77 tokenizer
// clock, reset, fall-through byte source and stimulus streams
// greedy reference model, token checks and stream rebuild
`timescale 1ns/1ps
`default_nettype none

module tb_lz;
  import lz_pkg::*;

  localparam int TIMEOUT = 2000;

  logic             clk = 1'b0;
  logic             rstn;
  logic             start_i;
  logic [CNT_W-1:0] cfg_len_i;
  logic             src_rd_o;
  byte_t            src_data_i = '0;
  logic             tok_valid_o;
  lz_token_t        tok_o;
  logic             done_o;

  byte_t       stream [0:63];
  int          src_idx = 0;
  lz_token_t   exp_q[$];
  lz_token_t   got_q[$];
  int          tok_idx = 0;
  int          emitted = 0;
  logic        last_d = 1'b0;
  logic        stream_done = 1'b0;
  int          tok_errors = 0;
  int          stream_errors = 0;
  int          timeout_errors = 0;
  int          prop_errors = 0;

  lz_top dut_i (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (start_i),
    .cfg_len_i   (cfg_len_i),
    .src_rd_o    (src_rd_o),
    .src_data_i  (src_data_i),
    .tok_valid_o (tok_valid_o),
    .tok_o       (tok_o),
    .done_o      (done_o)
  );

  always #20 clk = ~clk;

  // ----------------------------------------
  // byte source
  // ----------------------------------------
  // head byte stays on src_data_i until it is read
  always @(posedge clk) begin
    if (start_i) begin
      src_idx    <= 0;
      src_data_i <= stream[0];
    end else if (src_rd_o) begin
      src_idx    <= src_idx + 1;
      src_data_i <= stream[src_idx + 1];
    end
  end

  function automatic string tok_text(lz_token_t t);
    if (t.is_lit) begin
      return $sformatf("lit %h last %0d", t.payload.lit.data, t.last);
    end
    return $sformatf("len %0d dst %0d last %0d", t.payload.pair.len, t.payload.pair.dst, t.last);
  endfunction

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  // greedy pick of the longest match and the smallest distance on a tie
  task automatic build_expected(input int n);
    int        p;
    int        d;
    int        l;
    int        look;
    int        best_len;
    int        best_dst;
    lz_token_t t;
    exp_q.delete();
    p = 0;
    while (p < n) begin
      look     = (n - p < MAX_LEN) ? n - p : MAX_LEN;
      best_len = 0;
      best_dst = 0;
      for (d = 1; d <= WIN_SIZE && d <= p; d++) begin
        l = 0;
        while (l < look && l < d && stream[p + l] == stream[p + l - d]) begin
          l++;
        end
        if (l > best_len) begin
          best_len = l;
          best_dst = d;
        end
      end
      t = '0;
      if (best_len >= MIN_LEN) begin
        t.payload.pair.len = LEN_W'(best_len);
        t.payload.pair.dst = DST_W'(best_dst);
      end else begin
        t.is_lit           = 1'b1;
        t.payload.lit.data = stream[p];
        best_len           = 1;
      end
      t.last = (p + best_len == n);
      exp_q.push_back(t);
      p += best_len;
    end
  endtask

  // ----------------------------------------
  // token monitor
  // ----------------------------------------
  task automatic check_token();
    lz_token_t exp_tok;
    exp_tok = '0;
    got_q.push_back(tok_o);
    assert (tok_idx < exp_q.size()) else begin
      $display("CHECK FAILED at %0t: token %0d beyond the %0d expected",
               $time, tok_idx, exp_q.size());
      tok_errors++;
    end
    if (tok_idx < exp_q.size()) begin
      exp_tok = exp_q[tok_idx];
      assert (tok_o == exp_tok) else begin
        $display("CHECK FAILED at %0t: token %0d got %s expected %s",
                 $time, tok_idx, tok_text(tok_o), tok_text(exp_tok));
        tok_errors++;
      end
    end
    if (tok_o.is_lit) begin
      emitted++;
    end else begin
      // limits that hold whatever the model says
      assert (tok_o.payload.pair.len >= LEN_W'(MIN_LEN) &&
              tok_o.payload.pair.len <= LEN_W'(MAX_LEN) &&
              int'(tok_o.payload.pair.dst) <= emitted &&
              tok_o.payload.pair.dst <= DST_W'(WIN_SIZE)) else begin
        $display("CHECK FAILED at %0t: match %s out of range after %0d bytes",
                 $time, tok_text(tok_o), emitted);
        tok_errors++;
      end
      emitted += int'(tok_o.payload.pair.len);
    end
    tok_idx++;
  endtask

  always @(posedge clk) begin
    last_d <= tok_valid_o && tok_o.last;
    if (start_i) begin
      stream_done <= 1'b0;
      got_q.delete();
      tok_idx = 0;
      emitted = 0;
    end else if (done_o) begin
      stream_done <= 1'b1;
    end
    if (rstn) begin
      assert (done_o == last_d) else begin
        $display("CHECK FAILED at %0t: done_o %0d, last token one cycle before %0d",
                 $time, done_o, last_d);
        tok_errors++;
      end
    end
    if (tok_valid_o) begin
      check_token();
    end
  end

  // ----------------------------------------
  // one stream from start to done
  // ----------------------------------------
  task automatic run_stream(input string name, input int n);
    int        cycles;
    int        pos;
    int        lasts;
    int        bad;
    int        j;
    byte_t     out [0:63];
    lz_token_t t;
    build_expected(n);
    @(posedge clk);
    start_i   <= 1'b1;
    cfg_len_i <= CNT_W'(n);
    @(posedge clk);
    start_i <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!stream_done && cycles < TIMEOUT);
    if (!stream_done) begin
      $display("timeout: stream %s gave no done pulse within %0d cycles", name, TIMEOUT);
      timeout_errors++;
    end else begin
      // rebuild the bytes from the tokens
      pos   = 0;
      lasts = 0;
      bad   = 0;
      foreach (got_q[i]) begin
        t = got_q[i];
        if (t.last) begin
          lasts++;
        end
        if (t.is_lit) begin
          out[pos] = t.payload.lit.data;
          pos++;
        end else begin
          for (j = 0; j < int'(t.payload.pair.len); j++) begin
            out[pos] = out[pos - int'(t.payload.pair.dst)];
            pos++;
          end
        end
      end
      for (j = 0; j < n && j < pos; j++) begin
        if (out[j] != stream[j]) begin
          bad++;
        end
      end
      assert (got_q.size() == exp_q.size()) else begin
        $display("CHECK FAILED at %0t: stream %s gave %0d tokens, expected %0d",
                 $time, name, got_q.size(), exp_q.size());
        stream_errors++;
      end
      assert (lasts == 1 && got_q.size() > 0 && got_q[got_q.size() - 1].last) else begin
        $display("CHECK FAILED at %0t: stream %s has %0d last tokens", $time, name, lasts);
        stream_errors++;
      end
      assert (pos == n && bad == 0) else begin
        $display("CHECK FAILED at %0t: stream %s rebuilds %0d bytes of %0d, %0d differ",
                 $time, name, pos, n, bad);
        stream_errors++;
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int i;
    int s;
    void'($urandom(32'h475a));
    rstn      = 1'b0;
    start_i   = 1'b0;
    cfg_len_i = '0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;

    // quiet outputs before any start
    repeat (5) begin
      @(posedge clk);
      assert (!src_rd_o && !tok_valid_o && !done_o) else begin
        $display("CHECK FAILED at %0t: outputs active before start", $time);
        stream_errors++;
      end
    end

    for (i = 0; i < 12; i++) begin
      stream[i] = byte_t'(8'h01 + i * 8'h11);
    end
    run_stream("distinct", 12);

    for (i = 0; i < 20; i++) begin
      stream[i] = byte_t'(8'ha0 + i % 4);
    end
    run_stream("repeat4", 20);

    for (i = 0; i < 30; i++) begin
      stream[i] = 8'h5a;
    end
    run_stream("run30", 30);

    // two bytes left at the end fall back to literals
    for (i = 0; i < 10; i++) begin
      stream[i] = byte_t'(8'h30 + i % 4);
    end
    run_stream("tail", 10);

    for (i = 0; i < 40; i++) begin
      stream[i] = byte_t'(8'h40 + i % 13);
    end
    run_stream("period13", 40);

    stream[0] = 8'hee;
    run_stream("single", 1);

    for (s = 0; s < 3; s++) begin
      for (i = 0; i < 40; i++) begin
        stream[i] = byte_t'(8'h61 + ($urandom % 4));
      end
      run_stream("random", 40);
    end

    repeat (2) @(posedge clk);
    prop_errors = dut_i.props_i.err_cnt;
    $display("errors: %0d token, %0d stream, %0d timeout, %0d protocol",
             tok_errors, stream_errors, timeout_errors, prop_errors);
    if (tok_errors + stream_errors + timeout_errors + prop_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== window/lz_window.sv ====
// history window and lookahead storage
// fetched bytes fill the lookahead at its first free slot
// consumed bytes leave the lookahead head and enter the history
// history entry 0 holds the newest byte at distance 1
`timescale 1ns/1ps
`default_nettype none

module lz_window (
  input  logic                                 clk,
  input  logic                                 rstn,
  input  lz_pkg::lz_ctrl_t                     ctrl_i,
  input  lz_pkg::byte_t                        src_data_i,
  input  lz_pkg::consume_t                     consume_i,
  output lz_pkg::byte_t [lz_pkg::MAX_LEN-1:0]  look_o,
  output lz_pkg::byte_t [lz_pkg::WIN_SIZE-1:0] win_o
);
  import lz_pkg::*;

  byte_t [MAX_LEN-1:0]  look_q;
  byte_t [MAX_LEN-1:0]  look_d;
  byte_t [WIN_SIZE-1:0] win_q;
  byte_t [WIN_SIZE-1:0] win_d;

  // ----------------------------------------
  // next contents
  // ----------------------------------------
  always_comb begin
    look_d = look_q;
    win_d  = win_q;
    if (ctrl_i.fetch) begin
      // append behind the valid lookahead bytes
      for (int i = 0; i < MAX_LEN; i++) begin
        if (int'(ctrl_i.look_cnt) == i) begin
          look_d[i] = src_data_i;
        end
      end
    end else if (consume_i.valid) begin
      // one byte per pass starting at the head
      for (int s = 0; s < MAX_LEN; s++) begin
        if (s < int'(consume_i.len)) begin
          win_d  = {win_d[WIN_SIZE-2:0], look_q[s]};
          look_d = {byte_t'(0), look_d[MAX_LEN-1:1]};
        end
      end
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      look_q <= '0;
      win_q  <= '0;
    end else begin
      look_q <= look_d;
      win_q  <= win_d;
    end
  end

  assign look_o = look_q;
  assign win_o  = win_q;

endmodule

`default_nettype wire
